/* design/uart_line_pkg.sv */
package uart_line_pkg;

  // ======================================================================
  // Bit timing
  // ======================================================================

  // Clock cycles per UART bit. This build runs a short bit for simulation.
  // At 50 MHz and 115200 baud the value would be 434.
  localparam int CLKS_PER_BIT = 16;

  // ======================================================================
  // Frame shape
  // ======================================================================

  localparam int DATA_BITS = 8;   // Sent LSB first.

  // One start bit, the data bits, one odd-parity bit and one stop bit.
  localparam int FRAME_BITS = DATA_BITS + 3;

  // Position of the stop bit when counting the bits after the start bit.
  // The parity bit sits just before it.
  localparam int STOP_POS = DATA_BITS + 1;

endpackage

/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // ======================================================================
  // Command word layout
  // ======================================================================

  localparam int CMD_WIDTH  = 16;
  localparam int READ_WIDTH = 8;

  // Bit 15 is the operation flag, 1 for write and 0 for read.
  localparam int CMD_RW_BIT = 15;

  // The register address sits directly below the operation flag.
  localparam int ADDR_WIDTH = 7;
  localparam int ADDR_LSB   = CMD_RW_BIT - ADDR_WIDTH;

  // ======================================================================
  // Command timing
  // ======================================================================

  // Idle cycles between the header byte and the data byte of a write.
  localparam int BYTE_GAP_CYCLES = 100;

  // Cycles allowed after the header stop bit for the response start bit.
  localparam int RESP_TIMEOUT_CYCLES = 400;

  // One counter serves both waits, so it is sized for the longer one.
  localparam int WAIT_MAX_CYCLES = (RESP_TIMEOUT_CYCLES > BYTE_GAP_CYCLES) ?
                                   RESP_TIMEOUT_CYCLES : BYTE_GAP_CYCLES;
  localparam int WAIT_CNT_WIDTH  = $clog2(WAIT_MAX_CYCLES);

endpackage

/* design/uart_tx_frame.sv */
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int clks_per_bit = uart_line_pkg::CLKS_PER_BIT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                tx_start,
  input  logic [uart_line_pkg::DATA_BITS-1:0] tx_data,
  output logic                                tx,
  output logic                                tx_busy,
  output logic                                tx_done
);

  import uart_line_pkg::*;

  localparam int BAUD_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int BIT_W  = $clog2(FRAME_BITS);

  logic [BAUD_W-1:0]     baud_cnt;
  logic [BIT_W-1:0]      bit_cnt;     // Index of the bit now on the line.
  logic [FRAME_BITS-2:0] shift_reg;   // Bits still to go after the start bit.
  logic                  load;
  logic                  bit_end;

  assign load    = tx_start && !tx_busy;
  assign bit_end = (baud_cnt == BAUD_W'(clks_per_bit - 1));

  // ======================================================================
  // Line control
  // ======================================================================

  // The start bit goes out on the load edge, and each later bit follows
  // a full bit period after the one before it.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      tx_done  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (load)
      begin
        tx       <= 1'b0;   // Start bit.
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
      else if (tx_busy)
      begin
        if (bit_end)
        begin
          baud_cnt <= '0;
          if (bit_cnt == BIT_W'(FRAME_BITS - 1))
          begin
            // End of the stop bit.
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            tx_done <= 1'b1;
          end
          else
          begin
            tx      <= shift_reg[0];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        else
          baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // ======================================================================
  // Frame shifter
  // ======================================================================

  // Odd parity is formed once at load. Ones fill in behind, so the stop
  // bit and the idle level come out of the same register.
  always_ff @(posedge clk)
  begin
    if (load)
      shift_reg <= {1'b1, ~^tx_data, tx_data};
    else if (tx_busy && bit_end)
      shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
  end

endmodule

/* design/uart_rx_frame.sv */
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int clks_per_bit = uart_line_pkg::CLKS_PER_BIT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rx_enable,
  input  logic                                rx,
  output logic                                rx_active,
  output logic [uart_line_pkg::DATA_BITS-1:0] rx_data,
  output logic                                rx_valid,
  output logic                                rx_frame_err
);

  import uart_line_pkg::*;

  localparam int BAUD_W   = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int BIT_W    = $clog2(FRAME_BITS);
  localparam int HALF_BIT = (clks_per_bit > 1) ? clks_per_bit / 2 : 1;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS,
    RX_TAIL
  } rx_state_t;

  rx_state_t         state;
  logic [2:0]        rx_hist;      // Two synchronizer stages and one of history.
  logic              rx_sync;
  logic              fall_edge;
  logic              frame_start;
  logic              half_hit;
  logic              full_hit;
  logic [BAUD_W-1:0] baud_cnt;
  logic [BIT_W-1:0]  bit_cnt;      // Counts data, parity and stop bits.
  logic              parity_acc;

  assign rx_sync     = rx_hist[1];
  assign fall_edge   = rx_hist[2] && !rx_hist[1];
  assign frame_start = (state == RX_IDLE) && rx_enable && fall_edge;
  assign rx_active   = (state != RX_IDLE) || frame_start;
  assign half_hit    = (baud_cnt == BAUD_W'(HALF_BIT - 1));
  assign full_hit    = (baud_cnt == BAUD_W'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_hist <= '1;
    else
      rx_hist <= {rx_hist[1:0], rx};
  end

  // ======================================================================
  // Frame FSM
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= RX_IDLE;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
      parity_acc   <= 1'b0;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          if (frame_start)
          begin
            baud_cnt <= '0;
            state    <= RX_START;
          end
        end
        RX_START:
        begin
          if (half_hit)
          begin
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            parity_acc <= 1'b0;
            // A high level at mid start bit was only a glitch.
            if (rx_sync)
              state <= RX_IDLE;
            else
              state <= RX_BITS;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (full_hit)
          begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_W'(STOP_POS))
            begin
              // Data and parity together must hold an odd number of ones.
              rx_frame_err <= !parity_acc || !rx_sync;
              state        <= RX_TAIL;
            end
            else
            begin
              parity_acc <= parity_acc ^ rx_sync;
              bit_cnt    <= bit_cnt + 1'b1;
            end
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_TAIL:
        begin
          if (half_hit)
          begin
            baud_cnt <= '0;
            rx_valid <= 1'b1;
            state    <= RX_IDLE;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first and shift in from the top.
  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && full_hit && bit_cnt < BIT_W'(DATA_BITS))
      rx_data <= {rx_sync, rx_data[DATA_BITS-1:1]};
  end

endmodule

/* design/uart_cmd_engine.sv */
`timescale 1ns/1ps

module uart_cmd_engine (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]   cmd_in,
  input  logic                                 cmd_vld,
  output logic                                 cmd_rdy,
  output logic                                 tx_start,
  output logic [uart_line_pkg::DATA_BITS-1:0]  tx_data,
  input  logic                                 tx_busy,
  input  logic                                 tx_done,
  output logic                                 rx_enable,
  input  logic                                 rx_active,
  input  logic [uart_line_pkg::DATA_BITS-1:0]  rx_data,
  input  logic                                 rx_valid,
  input  logic                                 rx_frame_err,
  output logic [uart_cmd_pkg::READ_WIDTH-1:0]  read_data,
  output logic                                 read_valid,
  output logic                                 read_err
);

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_GAP,
    ST_DATA,
    ST_WAIT_RESP,
    ST_RECEIVE,
    ST_REPORT
  } state_t;

  state_t                    state;
  logic [WAIT_CNT_WIDTH-1:0] wait_cnt;   // Byte gap and response timeout.
  logic                      is_write;
  logic [DATA_BITS-1:0]      wr_byte;
  logic                      cmd_take;
  logic                      gap_done;
  logic                      resp_timeout;
  logic                      resp_done;

  assign cmd_rdy   = (state == ST_IDLE);
  assign cmd_take  = cmd_vld && cmd_rdy;
  assign rx_enable = (state == ST_WAIT_RESP) || (state == ST_RECEIVE);

  assign gap_done     = (wait_cnt == WAIT_CNT_WIDTH'(BYTE_GAP_CYCLES - 1));
  assign resp_timeout = (state == ST_WAIT_RESP) && !rx_active &&
                        (wait_cnt == WAIT_CNT_WIDTH'(RESP_TIMEOUT_CYCLES - 1));
  assign resp_done    = (state == ST_RECEIVE) && rx_valid;

  // ======================================================================
  // Command sequencer
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      wait_cnt   <= '0;
      tx_start   <= 1'b0;
      read_valid <= 1'b0;
    end
    else
    begin
      tx_start   <= 1'b0;
      read_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (cmd_take)
          begin
            tx_start <= 1'b1;   // Header byte.
            state    <= ST_HEADER;
          end
        end
        ST_HEADER:
        begin
          if (tx_done)
          begin
            wait_cnt <= '0;
            if (is_write)
              state <= ST_GAP;
            else
              state <= ST_WAIT_RESP;
          end
        end
        ST_GAP:
        begin
          if (gap_done && !tx_busy)
          begin
            tx_start <= 1'b1;
            state    <= ST_DATA;
          end
          else if (!gap_done)
            wait_cnt <= wait_cnt + 1'b1;
        end
        ST_DATA:
        begin
          if (tx_done)
            state <= ST_IDLE;
        end
        ST_WAIT_RESP:
        begin
          if (rx_active)
            state <= ST_RECEIVE;
          else if (resp_timeout)
          begin
            read_valid <= 1'b1;
            state      <= ST_REPORT;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        ST_RECEIVE:
        begin
          if (resp_done)
          begin
            read_valid <= 1'b1;
            state      <= ST_REPORT;
          end
          else if (!rx_active)
            state <= ST_WAIT_RESP;   // Start bit was a glitch, keep waiting.
        end
        ST_REPORT: state <= ST_IDLE;  // Result pulse is on the port now.
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // ======================================================================
  // Command and result registers
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (cmd_take)
    begin
      is_write <= cmd_in[CMD_RW_BIT];
      wr_byte  <= cmd_in[DATA_BITS-1:0];
      tx_data  <= {cmd_in[CMD_RW_BIT], cmd_in[ADDR_LSB +: ADDR_WIDTH]};
    end
    else if (state == ST_GAP)
      tx_data <= wr_byte;

    if (resp_timeout)
    begin
      read_err  <= 1'b1;
      read_data <= '0;
    end
    else if (resp_done)
    begin
      read_err  <= rx_frame_err;
      read_data <= rx_frame_err ? '0 : rx_data;   // No data on a bad frame.
    end
  end

endmodule

/* design/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  input  logic                                rx,
  output logic                                tx,
  output logic [uart_cmd_pkg::READ_WIDTH-1:0] read_data,
  output logic                                read_valid,
  output logic                                read_err
);

  import uart_line_pkg::*;

  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_data;
  logic                 tx_busy;
  logic                 tx_done;
  logic                 rx_enable;
  logic                 rx_active;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_frame_err;

  uart_cmd_engine u_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done),
    .rx_enable    (rx_enable),
    .rx_active    (rx_active),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .read_err     (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_enable    (rx_enable),
    .rx           (rx),
    .rx_active    (rx_active),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err)
  );

endmodule

/* testbench/tb_uart_cmd_top.sv */
`timescale 1ns/1ps

module tb_uart_cmd_top;

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  localparam int NUM_ENTRIES    = 10;
  localparam int NUM_REGS       = 1 << ADDR_WIDTH;
  localparam int MODE_NORMAL    = 0;
  localparam int MODE_BAD_PAR   = 1;
  localparam int MODE_SILENT    = 2;
  localparam int SLAVE_TURN     = 50;   // Cycles from header end to response.
  localparam int FRAME_CYCLES   = FRAME_BITS * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES *
                                  (3 * FRAME_CYCLES + BYTE_GAP_CYCLES +
                                   RESP_TIMEOUT_CYCLES + 100);

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic [READ_WIDTH-1:0] read_data;
  logic                  read_valid;
  logic                  read_err;

  logic [CMD_WIDTH-1:0]  cmd_tab      [NUM_ENTRIES];
  int                    mode_tab     [NUM_ENTRIES];
  logic [READ_WIDTH-1:0] exp_data_tab [NUM_ENTRIES];
  logic                  exp_err_tab  [NUM_ENTRIES];
  int                    n_entries;

  logic [DATA_BITS-1:0] slave_regs  [NUM_REGS];
  logic [DATA_BITS-1:0] shadow_regs [NUM_REGS];   // Expected register contents.
  int                   seed;
  int                   resp_mode;
  int                   headers_seen = 0;
  int                   read_pulses  = 0;
  int                   held_cycles  = 0;
  int                   cycle_cnt    = 0;

  uart_cmd_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_valid (read_valid),
    .read_err   (read_err)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      $display("ERROR: the run went past %0d cycles without finishing the table",
               TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1);
    end
  end

  always @(negedge clk)
  begin
    if (read_valid)
      read_pulses <= read_pulses + 1;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // ======================================================================
  // Slave model
  // ======================================================================

  // Samples every bit near its middle on the falling clock edge.
  task automatic decode_tx_frame(output logic [DATA_BITS-1:0] data, output int start_cycle);
    logic [DATA_BITS-1:0] bits;
    logic                 par;
    logic                 stop;
    @(negedge tx);
    @(negedge clk);
    start_cycle = cycle_cnt;
    repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
    check_value(tx, 1'b0, "start bit on tx");
    for (int i = 0; i < DATA_BITS; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      bits[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop = tx;
    check_value(^{par, bits}, 1'b1, "odd parity on tx frame");
    check_value(stop, 1'b1, "stop bit on tx frame");
    repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Ride out the stop bit.
    data = bits;
  endtask

  task automatic drive_rx_frame(input logic [DATA_BITS-1:0] data, input logic bad_parity);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, !(^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  initial
  begin : slave_model
    logic [DATA_BITS-1:0] header;
    logic [DATA_BITS-1:0] wr_byte;
    int                   hdr_start;
    int                   data_start;
    wait (rst_n);
    forever
    begin
      decode_tx_frame(header, hdr_start);
      check_value(headers_seen < n_entries, 1'b1, "header beyond the end of the table");
      check_value(header, cmd_tab[headers_seen][CMD_WIDTH-1:DATA_BITS],
                  "header byte on tx");
      headers_seen++;
      if (header[DATA_BITS-1])
      begin
        decode_tx_frame(wr_byte, data_start);
        check_value(data_start - hdr_start - FRAME_CYCLES >= BYTE_GAP_CYCLES, 1'b1,
                    "idle gap between header and data bytes");
        check_value(wr_byte, cmd_tab[headers_seen-1][DATA_BITS-1:0], "data byte on tx");
        slave_regs[header[ADDR_WIDTH-1:0]] = wr_byte;
      end
      else
      begin
        repeat (SLAVE_TURN) @(negedge clk);
        if (resp_mode == MODE_NORMAL)
          drive_rx_frame(slave_regs[header[ADDR_WIDTH-1:0]], 1'b0);
        else if (resp_mode == MODE_BAD_PAR)
          drive_rx_frame(slave_regs[header[ADDR_WIDTH-1:0]], 1'b1);
      end
    end
  end

  // ======================================================================
  // Stimulus table and host side
  // ======================================================================

  task automatic add_entry(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_BITS-1:0] data, input int mode);
    cmd_tab[n_entries]  = {is_write, addr, data};
    mode_tab[n_entries] = mode;
    exp_data_tab[n_entries] = '0;
    exp_err_tab[n_entries]  = 1'b0;
    if (is_write)
      shadow_regs[addr] = data;
    else if (mode == MODE_NORMAL)
      exp_data_tab[n_entries] = shadow_regs[addr];
    else
      exp_err_tab[n_entries] = 1'b1;   // Bad or missing response reads as zero.
    n_entries++;
  endtask

  // Called on a falling edge. The command moves on the next rising edge
  // that finds cmd_rdy high.
  task automatic issue_command(input logic [CMD_WIDTH-1:0] cmd);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      held_cycles++;
      @(negedge clk);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  initial
  begin : stimulus
    logic [31:0] rnd;
    int          reads;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    resp_mode = MODE_NORMAL;
    n_entries = 0;
    reads     = 0;
    seed      = 32'h598b1857;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      rnd = $random(seed);
      slave_regs[i]  = rnd[DATA_BITS-1:0];
      shadow_regs[i] = rnd[DATA_BITS-1:0];
    end

    add_entry(1'b1, 7'h12, 8'hA5, MODE_NORMAL);
    add_entry(1'b1, 7'h7F, 8'h3C, MODE_NORMAL);   // Queued behind a busy engine.
    add_entry(1'b0, 7'h12, 8'h00, MODE_NORMAL);
    add_entry(1'b0, 7'h05, 8'h00, MODE_NORMAL);
    add_entry(1'b0, 7'h33, 8'h00, MODE_BAD_PAR);
    add_entry(1'b0, 7'h40, 8'h00, MODE_SILENT);
    add_entry(1'b0, 7'h7F, 8'h00, MODE_NORMAL);
    add_entry(1'b1, 7'h05, 8'h5A, MODE_NORMAL);
    add_entry(1'b1, 7'h05, 8'hC3, MODE_NORMAL);
    add_entry(1'b0, 7'h05, 8'h00, MODE_NORMAL);

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value(tx, 1'b1, "tx after reset");
    check_value(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_value(read_valid, 1'b0, "read_valid after reset");
    repeat (50)
    begin
      @(negedge clk);
      check_value(tx, 1'b1, "tx idle before the first command");
    end
    check_value(headers_seen, 0, "frames seen before the first command");

    for (int i = 0; i < n_entries; i++)
    begin
      resp_mode = mode_tab[i];
      issue_command(cmd_tab[i]);
      if (!cmd_tab[i][CMD_RW_BIT])
      begin
        while (!read_valid)
          @(negedge clk);
        reads++;
        check_value(read_data, exp_data_tab[i], $sformatf("entry %0d read data", i));
        check_value(read_err, exp_err_tab[i], $sformatf("entry %0d read error", i));
        check_value(headers_seen, i + 1, $sformatf("entry %0d header count", i));
      end
    end

    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk);
    check_value(headers_seen, n_entries, "headers seen over the whole table");
    check_value(read_pulses, reads, "read_valid pulses over the whole table");
    check_value(held_cycles > 0, 1'b1, "cmd_vld held while the engine was busy");
    for (int a = 0; a < NUM_REGS; a++)
      check_value(slave_regs[a], shadow_regs[a], $sformatf("slave register 0x%0h", a));

    $display("All tests passed!");
    $finish;
  end

endmodule

/* tb.f */
design/uart_line_pkg.sv
design/uart_cmd_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_engine.sv
design/uart_cmd_top.sv
testbench/tb_uart_cmd_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log.

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_uart_cmd_top -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "Test failures found" "$LOG" && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
